// File: hw/bus_mapper_params.svh
/*
 * Sizing constants for the bus mapper.
 * Included by every module that needs the region count, the register
 * count or the MCU vblank pulse length.
 */
`ifndef BUS_MAPPER_PARAMS_SVH
`define BUS_MAPPER_PARAMS_SVH

// address regions decoded by the mapper
`define BM_REGIONS 8

// byte registers seen by the CPU and the MCU
`define BM_REGS 32

// MCU vblank interrupt pulse, in clk cycles
`define BM_VINT_LEN 64

`endif

// File: hw/bus_mapper_pkg.sv
/*
 * Shared types of the bus mapper: the CPU bus cycle, the MCU register
 * port, the per-region configuration and the bus master command.
 * Register map, byte addresses as seen by the MCU or CPU addr[5:1]:
 *   0,1 data hi/lo   2 control (b0 cpu reset, b1 halt)   3 sound out
 *   4 MCU ipl   5 command (01 write, 10 read)   7-9 read addr   10-12 write addr
 *   16+2r size/wait of region r   17+2r base of region r
 */
package bus_mapper_pkg;

    typedef struct packed {
        logic        as_n;
        logic        rnw;
        logic [1:0]  dsn;     // upper, lower strobes
        logic [2:0]  fc;
        logic [23:1] addr;    // word address
        logic [15:0] dout;    // data written by the CPU
    } cpu_bus_t;

    typedef struct packed {
        logic       acc;
        logic       wr;
        logic [4:0] addr;
        logic [7:0] dout;     // data written by the MCU
    } mcu_req_t;

    // size register kept as a byte and also decoded into fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] rsvd;
            logic [1:0] wait_code;  // 3 uses the external ack
            logic [1:0] size;       // 64k, 128k, 512k, 2M
        } f;
    } region_ctrl_u;

    typedef struct packed {
        logic [7:0]   base;
        region_ctrl_u ctrl;
    } region_cfg_t;

    typedef struct packed {
        logic        rd;          // one cycle pulse
        logic        wr;          // one cycle pulse
        logic [23:1] rd_addr;
        logic [23:1] wr_addr;
        logic [15:0] wr_data;
    } mem_cmd_t;

endpackage

// File: hw/mapper_regs.sv
/*
 * Mapper register file. The CPU programs it while no region is active,
 * until the first MCU write hands control to the MCU for good.
 * Also holds the sound mailbox, the CPU reset/halt control, the command
 * pulses for the bus master and the MCU readback port.
 */
`timescale 1ns/1ps
`include "bus_mapper_params.svh"

module mapper_regs (
    input  logic                                       clk,
    input  logic                                       rst,
    input  bus_mapper_pkg::cpu_bus_t                   cpu,
    input  logic                                       region_none,
    input  bus_mapper_pkg::mcu_req_t                   mcu,
    input  logic                                       snd_wr,
    input  logic                                       snd_rd,
    input  logic [7:0]                                 snd_din,
    input  logic                                       rd_done,
    input  logic [15:0]                                rd_data,
    input  logic                                       bus_busy,
    input  logic                                       int_ack,
    output logic [7:0]                                 mcu_din,
    output logic [7:0]                                 snd_dout,
    output logic                                       snd_pbf,
    output logic                                       mcu_snd_int_n,
    output logic                                       cpu_rst,
    output logic                                       cpu_halt_n,
    output logic                                       mcu_mode,
    output logic [2:0]                                 ipl_reg,
    output bus_mapper_pkg::region_cfg_t [`BM_REGIONS-1:0] region_cfg,
    output bus_mapper_pkg::mem_cmd_t                   cmd
);
    localparam int REGION_BASE = `BM_REGS / 2;   // first size register

    logic [7:0] regs [0:`BM_REGS-1];
    logic       cpu_we;
    logic       mcu_we;
    logic       mcu_sel;
    logic       we;
    logic       we_l;
    logic [4:0] wsel;
    logic [7:0] wdata;
    logic       mcu_rd;
    logic       cmd_rd;
    logic       cmd_wr;
    logic       rst_aux;
    logic [7:0] snd_latch;

    assign cpu_we  = ~cpu.as_n & ~cpu.rnw & ~cpu.dsn[0] & region_none; // low byte only
    assign mcu_we  = mcu.acc & mcu.wr;
    assign mcu_sel = mcu_mode | mcu_we;   // an MCU write always wins
    assign we      = mcu_sel ? mcu_we : cpu_we;
    assign wsel    = mcu_sel ? mcu.addr : cpu.addr[5:1];
    assign wdata   = mcu_sel ? mcu.dout : cpu.dout[7:0];
    assign mcu_rd  = mcu.acc & ~mcu.wr;

    assign snd_dout   = regs[3];
    assign cpu_halt_n = ~regs[2][1];
    assign ipl_reg    = regs[4][2:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BM_REGS; i++) begin
                regs[i] <= 8'h00;
            end
            regs[4]  <= 8'h07;   // no MCU interrupt level
            we_l     <= 1'b0;
            mcu_mode <= 1'b0;
            cmd_rd   <= 1'b0;
            cmd_wr   <= 1'b0;
            snd_pbf  <= 1'b0;
        end else begin
            we_l   <= we;
            cmd_rd <= 1'b0;
            cmd_wr <= 1'b0;
            if (mcu_we) mcu_mode <= 1'b1;   // sticky until reset
            if (we && !we_l) begin
                regs[wsel] <= wdata;
                if (wsel == 5'd3) snd_pbf <= 1'b1;
                if (wsel == 5'd5) begin
                    cmd_wr <= wdata[1:0] == 2'b01;
                    cmd_rd <= wdata[1:0] == 2'b10;
                end
            end
            if (snd_rd) snd_pbf <= 1'b0;
            if (rd_done) begin
                regs[0] <= rd_data[15:8];
                regs[1] <= rd_data[7:0];
            end
            if (int_ack) regs[4][2:0] <= 3'b111;
        end
    end

    // sound CPU to MCU direction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch     <= 8'h00;
            mcu_snd_int_n <= 1'b1;
        end else begin
            if (snd_wr) begin
                snd_latch     <= snd_din;
                mcu_snd_int_n <= 1'b0;
            end
            if (mcu_rd && mcu.addr[1:0] == 2'd3) mcu_snd_int_n <= 1'b1;
        end
    end

    // two stage reset to the CPU
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rst_aux <= 1'b1;
            cpu_rst <= 1'b1;
        end else begin
            rst_aux <= regs[2][0];
            cpu_rst <= rst_aux;
        end
    end

    always_ff @(posedge clk) begin
        case (mcu.addr[1:0])
            2'd0: mcu_din <= regs[0];
            2'd1: mcu_din <= regs[1];
            2'd2: mcu_din <= {1'b0, bus_busy, 4'b0000, cpu_halt_n, ~cpu_rst};
            default: mcu_din <= snd_latch;
        endcase
    end

    always_comb begin
        for (int r = 0; r < `BM_REGIONS; r++) begin
            region_cfg[r].ctrl.raw = regs[REGION_BASE + 2 * r];
            region_cfg[r].base     = regs[REGION_BASE + 2 * r + 1];
        end
    end

    always_comb begin
        cmd.rd      = cmd_rd;
        cmd.wr      = cmd_wr;
        cmd.rd_addr = {regs[7][6:0], regs[8], regs[9]};
        cmd.wr_addr = {regs[10][6:0], regs[11], regs[12]};
        cmd.wr_data = {regs[0], regs[1]};
    end

endmodule

// File: hw/region_decode.sv
/*
 * Address region decoder. Compares the top address bits against each
 * region base under its size code and returns a one-hot active vector,
 * lowest region first, together with the wait code of the winner.
 */
`timescale 1ns/1ps
`include "bus_mapper_params.svh"

module region_decode (
    input  logic [23:1]                                addr,
    input  logic [2:0]                                 fc,
    input  bus_mapper_pkg::region_cfg_t [`BM_REGIONS-1:0] region_cfg,
    output logic [`BM_REGIONS-1:0]                     active,
    output logic [1:0]                                 wait_code
);

    always_comb begin
        logic       found;
        logic       hit;
        logic [7:0] base;

        found     = 1'b0;
        hit       = 1'b0;
        base      = 8'h00;
        active    = '0;
        wait_code = 2'd0;
        for (int r = 0; r < `BM_REGIONS; r++) begin
            base = region_cfg[r].base;
            case (region_cfg[r].ctrl.f.size)
                2'd0: hit = addr[23:16] == base;          // 64 kB
                2'd1: hit = addr[23:17] == base[7:1];     // 128 kB
                2'd2: hit = addr[23:19] == base[7:3];     // 512 kB
                default: hit = addr[23:21] == base[7:5];  // 2 MB
            endcase
            if (hit && !found) begin
                active[r] = 1'b1;
                wait_code = region_cfg[r].ctrl.f.wait_code;
                found     = 1'b1;
            end
        end
        // interrupt acknowledge space never selects memory
        if (fc == 3'b111) begin
            active    = '0;
            wait_code = 2'd0;
        end
    end

endmodule

// File: hw/dtack_timer.sv
/*
 * DTACK generator. A bus cycle that hits a region gets DTACK after
 * wait_code+1 clocks, or from the external acknowledge for code 3.
 * DTACK is released on the first edge that sees AS high.
 */
`timescale 1ns/1ps

module dtack_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       as_n,
    input  logic       region_hit,
    input  logic [1:0] wait_code,
    input  logic       ext_ack_n,
    output logic       dtack_n
);
    logic       in_cyc;   // accepted cycle is counting
    logic [1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n <= 1'b1;
            in_cyc  <= 1'b0;
            cnt     <= 2'd0;
        end else if (as_n) begin
            dtack_n <= 1'b1;
            in_cyc  <= 1'b0;
            cnt     <= 2'd0;
        end else if (!in_cyc) begin
            in_cyc <= region_hit;   // unmapped cycles get no DTACK
            cnt    <= 2'd0;
        end else if (wait_code == 2'd3) begin
            dtack_n <= ext_ack_n;
        end else if (cnt == wait_code) begin
            dtack_n <= 1'b0;
        end else begin
            cnt <= cnt + 2'd1;
        end
    end

endmodule

// File: hw/mcu_bus_master.sv
/*
 * Bus master for MCU commanded single word accesses. Requests the main
 * bus, takes it once granted and the CPU has left its cycle, runs one
 * read or write of at least 3 clocks and hands the bus back.
 */
`timescale 1ns/1ps

module mcu_bus_master (
    input  logic                     clk,
    input  logic                     rst,
    input  bus_mapper_pkg::mem_cmd_t cmd,
    input  logic                     bg_n,
    input  logic                     cpu_as_n,
    input  logic                     mem_busy,
    input  logic [15:0]              bus_dout,
    output logic                     br_n,
    output logic                     bgack_n,
    output logic                     owns_bus,
    output logic [23:1]              m_addr,
    output logic                     m_rnw,
    output logic                     rd_done,
    output logic [15:0]              rd_data,
    output logic                     busy
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_HOLD,
        ST_REL
    } state_t;

    state_t     state;
    logic       is_rd;
    logic [1:0] hold_cnt;

    assign owns_bus = state == ST_HOLD;
    assign busy     = state != ST_IDLE;
    assign m_rnw    = is_rd;
    assign m_addr   = is_rd ? cmd.rd_addr : cmd.wr_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            br_n     <= 1'b1;
            bgack_n  <= 1'b1;
            is_rd    <= 1'b0;
            hold_cnt <= 2'd0;
            rd_done  <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                ST_IDLE: if (cmd.rd || cmd.wr) begin
                    is_rd <= cmd.rd;
                    br_n  <= 1'b0;
                    state <= ST_REQ;
                end
                ST_REQ: if (!bg_n && cpu_as_n) begin   // CPU off the bus
                    bgack_n  <= 1'b0;
                    hold_cnt <= 2'd2;
                    state    <= ST_HOLD;
                end
                ST_HOLD: begin
                    if (hold_cnt != 2'd0) begin
                        hold_cnt <= hold_cnt - 2'd1;
                    end else if (!mem_busy) begin
                        rd_done <= is_rd;
                        bgack_n <= 1'b1;
                        br_n    <= 1'b1;
                        state   <= ST_REL;
                    end
                end
                default: state <= ST_IDLE;   // one idle clock for the grant to drop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_HOLD && hold_cnt == 2'd0 && !mem_busy) rd_data <= bus_dout;
    end

endmodule

// File: hw/irq_ctrl.sv
/*
 * Vertical blank interrupts. The CPU gets a level 4 request until it
 * acknowledges, or the MCU level once the MCU has taken control.
 * The MCU sees a fixed length low pulse on every vblank edge.
 */
`timescale 1ns/1ps
`include "bus_mapper_params.svh"

module irq_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic       int_ack,
    input  logic       mcu_mode,
    input  logic [2:0] ipl_reg,
    output logic [2:0] cpu_ipl_n,
    output logic       mcu_vint_n
);
    localparam int CW = $clog2(`BM_VINT_LEN);

    logic          vint_l;
    logic          vint_rise;
    logic          irq_n;
    logic [CW-1:0] vcnt;

    assign vint_rise = vint & ~vint_l;
    assign cpu_ipl_n = mcu_mode ? ipl_reg : {irq_n, 2'b11};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_l     <= 1'b0;
            irq_n      <= 1'b1;
            mcu_vint_n <= 1'b1;
            vcnt       <= '0;
        end else begin
            vint_l <= vint;
            if (int_ack) begin
                irq_n <= 1'b1;
            end else if (vint_rise) begin
                irq_n <= 1'b0;   // level 4
            end
            if (vint_rise) begin
                mcu_vint_n <= 1'b0;
                vcnt       <= CW'(`BM_VINT_LEN - 1);
            end else if (vcnt != '0) begin
                vcnt <= vcnt - CW'(1);
            end else begin
                mcu_vint_n <= 1'b1;
            end
        end
    end

endmodule

// File: hw/bus_mapper_top.sv
/*
 * Programmable memory mapper top level. Decodes the 68000 bus into
 * regions, paces DTACK, routes interrupts, and lets the MCU program the
 * mapper and borrow the main bus for single word accesses.
 */
`timescale 1ns/1ps
`include "bus_mapper_params.svh"

module bus_mapper_top (
    input  logic                    clk,
    input  logic                    rst,
    input  bus_mapper_pkg::cpu_bus_t cpu,
    input  logic                    ext_ack_n,
    input  logic                    bg_n,
    input  logic                    vint,
    input  bus_mapper_pkg::mcu_req_t mcu,
    input  logic                    snd_wr,
    input  logic                    snd_rd,
    input  logic [7:0]              snd_din,
    input  logic                    mem_busy,
    input  logic [15:0]             bus_dout,
    output logic                    dtack_n,
    output logic                    br_n,
    output logic                    bgack_n,
    output logic [2:0]              cpu_ipl_n,
    output logic                    cpu_vpa_n,
    output logic                    cpu_rst,
    output logic                    cpu_halt_n,
    output logic [`BM_REGIONS-1:0]  active,
    output logic [23:1]             addr_out,
    output logic [15:0]             bus_din,
    output logic                    bus_rnw,
    output logic                    bus_as_n,
    output logic [7:0]              snd_dout,
    output logic                    snd_pbf,
    output logic [7:0]              mcu_din,
    output logic [1:0]              mcu_intn
);
    import bus_mapper_pkg::*;

    region_cfg_t [`BM_REGIONS-1:0] region_cfg;
    mem_cmd_t    cmd;
    logic        int_ack;
    logic        mcu_mode;
    logic [2:0]  ipl_reg;
    logic [1:0]  wait_code;
    logic        owns_bus;
    logic [23:1] m_addr;
    logic        m_rnw;
    logic        rd_done;
    logic [15:0] rd_data;
    logic        bus_busy;
    logic        mcu_snd_int_n;
    logic        mcu_vint_n;

    assign int_ack   = &cpu.fc & ~cpu.as_n;   // autovectored
    assign cpu_vpa_n = ~int_ack;
    assign mcu_intn  = {mcu_snd_int_n, mcu_vint_n};

    // bus master overrides the CPU while it holds the bus
    assign addr_out = owns_bus ? m_addr : cpu.addr;
    assign bus_din  = owns_bus ? cmd.wr_data : cpu.dout;
    assign bus_rnw  = owns_bus ? m_rnw : cpu.rnw;
    assign bus_as_n = owns_bus ? 1'b0 : cpu.as_n;

    mapper_regs u_regs (
        .clk(clk), .rst(rst), .cpu(cpu), .region_none(~|active), .mcu(mcu),
        .snd_wr(snd_wr), .snd_rd(snd_rd), .snd_din(snd_din),
        .rd_done(rd_done), .rd_data(rd_data), .bus_busy(bus_busy), .int_ack(int_ack),
        .mcu_din(mcu_din), .snd_dout(snd_dout), .snd_pbf(snd_pbf),
        .mcu_snd_int_n(mcu_snd_int_n), .cpu_rst(cpu_rst), .cpu_halt_n(cpu_halt_n),
        .mcu_mode(mcu_mode), .ipl_reg(ipl_reg), .region_cfg(region_cfg), .cmd(cmd)
    );

    region_decode u_decode (
        .addr(addr_out), .fc(cpu.fc), .region_cfg(region_cfg),
        .active(active), .wait_code(wait_code)
    );

    dtack_timer u_dtack (
        .clk(clk), .rst(rst), .as_n(cpu.as_n), .region_hit(|active),
        .wait_code(wait_code), .ext_ack_n(ext_ack_n), .dtack_n(dtack_n)
    );

    mcu_bus_master u_master (
        .clk(clk), .rst(rst), .cmd(cmd), .bg_n(bg_n), .cpu_as_n(cpu.as_n),
        .mem_busy(mem_busy), .bus_dout(bus_dout), .br_n(br_n), .bgack_n(bgack_n),
        .owns_bus(owns_bus), .m_addr(m_addr), .m_rnw(m_rnw),
        .rd_done(rd_done), .rd_data(rd_data), .busy(bus_busy)
    );

    irq_ctrl u_irq (
        .clk(clk), .rst(rst), .vint(vint), .int_ack(int_ack), .mcu_mode(mcu_mode),
        .ipl_reg(ipl_reg), .cpu_ipl_n(cpu_ipl_n), .mcu_vint_n(mcu_vint_n)
    );

endmodule

// File: tb/bus_mapper_tb_tasks.svh
/*
 * Access tasks and tests for the bus mapper testbench.
 * Included inside the testbench module, uses its signals directly.
 */
`ifndef BUS_MAPPER_TB_TASKS_SVH
`define BUS_MAPPER_TB_TASKS_SVH

function automatic logic [15:0] fill_word(input logic [7:0] idx);
    return {idx ^ 8'h5a, ~idx};
endfunction

task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
endtask

task automatic end_test();
    tests++;
    $display("test %s %s, %0d errors", cur_test,
             (errors == test_err0) ? "passed" : "failed", errors - test_err0);
endtask

task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
        $display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
        errors++;
    end
endtask

task automatic report(input string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
endtask

task automatic cpu_idle();
    cpu.as_n = 1'b1;
    cpu.rnw  = 1'b1;
    cpu.dsn  = 2'b11;
    cpu.fc   = 3'b101;
endtask

// fc 111 keeps every region inactive so the write lands in the mapper
task automatic cpu_reg_write(input logic [4:0] idx, input logic [7:0] val);
    @(negedge clk);
    cpu.addr = {18'h3ffff, idx};
    cpu.dout = {8'h00, val};
    cpu.fc   = 3'b111;
    cpu.rnw  = 1'b0;
    cpu.dsn  = 2'b10;
    cpu.as_n = 1'b0;
    @(negedge clk);
    cpu_idle();
    @(negedge clk);
endtask

task automatic ack_cycle();
    @(negedge clk);
    cpu.fc   = 3'b111;
    cpu.rnw  = 1'b1;
    cpu.as_n = 1'b0;
    @(negedge clk);
    check_val("vpa_n", 32'(0), 32'(cpu_vpa_n));
    cpu_idle();
    @(negedge clk);
endtask

task automatic mcu_write(input logic [4:0] idx, input logic [7:0] val);
    @(negedge clk);
    mcu.acc  = 1'b1;
    mcu.wr   = 1'b1;
    mcu.addr = idx;
    mcu.dout = val;
    @(negedge clk);
    mcu.acc = 1'b0;
    mcu.wr  = 1'b0;
    @(negedge clk);
endtask

task automatic mcu_read(input logic [4:0] idx, output logic [7:0] val);
    @(negedge clk);
    mcu.acc  = 1'b1;
    mcu.wr   = 1'b0;
    mcu.addr = idx;
    @(negedge clk);
    val     = mcu_din;
    mcu.acc = 1'b0;
endtask

// lowest matching region under the size rules
function automatic logic [7:0] expect_active(input logic [22:0] a, input logic [2:0] fc,
                                             input logic [7:0] base [8],
                                             input logic [1:0] size [8]);
    logic [7:0] top;
    logic [7:0] res;
    logic       hit;

    top = a[22:15];
    res = 8'h00;
    for (int r = 0; r < 8; r++) begin
        case (size[r])
            2'd0: hit = top == base[r];
            2'd1: hit = top[7:1] == base[r][7:1];
            2'd2: hit = top[7:3] == base[r][7:3];
            default: hit = top[7:5] == base[r][7:5];
        endcase
        if (hit && res == 8'h00) res[r] = 1'b1;
    end
    if (fc == 3'b111) res = 8'h00;
    return res;
endfunction

task automatic reset_values();
    start_test("reset");
    check_val("cpu_rst during reset", 32'(1), 32'(cpu_rst));
    @(negedge clk);
    rst = 1'b0;
    check_val("br_n", 32'(1), 32'(br_n));
    check_val("bgack_n", 32'(1), 32'(bgack_n));
    check_val("dtack_n", 32'(1), 32'(dtack_n));
    check_val("mcu_intn", 32'(3), 32'(mcu_intn));
    check_val("snd_pbf", 32'(0), 32'(snd_pbf));
    check_val("cpu_ipl_n", 32'(7), 32'(cpu_ipl_n));
    repeat (3) @(negedge clk);
    check_val("cpu_rst after reset", 32'(0), 32'(cpu_rst));
    end_test();
endtask

task automatic region_sweep();
    logic [31:0] rnd;
    logic [22:0] a;
    logic [7:0]  base [8];
    logic [1:0]  size [8];

    start_test("region_decode");
    for (int r = 0; r < 8; r++) begin
        rnd     = $urandom();
        base[r] = rnd[7:0];
        size[r] = rnd[9:8];
        cpu_reg_write(5'(16 + 2 * r), {4'h0, rnd[11:10], rnd[9:8]});
        cpu_reg_write(5'(17 + 2 * r), rnd[7:0]);
    end
    for (int i = 0; i < 48; i++) begin
        rnd = $urandom();
        a   = rnd[22:0];
        if (rnd[31]) a[22:15] = base[rnd[26:24]];   // aim at a programmed base
        @(negedge clk);
        cpu.addr = a;
        cpu.fc   = (i % 6 == 5) ? 3'b111 : 3'b101;
        @(posedge clk);
        check_val("active", 32'(expect_active(a, cpu.fc, base, size)), 32'(active));
    end
    @(negedge clk);
    cpu_idle();
    end_test();
endtask

task automatic dtack_delays();
    logic [31:0] rnd;
    int          n;

    start_test("dtack");
    cpu_reg_write(5'd17, 8'ha5);   // region 0 wins over everything
    for (int c = 0; c < 4; c++) begin
        cpu_reg_write(5'd16, {4'h0, 2'(c), 2'b00});
        rnd = $urandom();
        @(negedge clk);
        cpu.addr  = {8'ha5, rnd[14:0]};
        cpu.rnw   = 1'b1;
        cpu.as_n  = 1'b0;
        ext_ack_n = 1'b1;
        if (c < 3) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (dtack_n && n < 10);
            check_val("dtack delay", 32'(c + 1), 32'(n - 1));
        end else begin
            repeat (5) @(negedge clk);
            check_val("dtack before ext ack", 32'(1), 32'(dtack_n));
            ext_ack_n = 1'b0;
            @(negedge clk);
            check_val("dtack on ext ack", 32'(0), 32'(dtack_n));
        end
        cpu_idle();
        ext_ack_n = 1'b1;
        @(negedge clk);
        check_val("dtack release", 32'(1), 32'(dtack_n));
    end
    end_test();
endtask

task automatic sound_mailbox();
    logic [31:0] rnd;
    logic [7:0]  val;

    start_test("sound");
    rnd = $urandom();
    cpu_reg_write(5'd3, rnd[7:0]);
    check_val("snd_dout", 32'(rnd[7:0]), 32'(snd_dout));
    check_val("snd_pbf set", 32'(1), 32'(snd_pbf));
    snd_rd = 1'b1;
    @(negedge clk);
    snd_rd = 1'b0;
    check_val("snd_pbf clear", 32'(0), 32'(snd_pbf));
    snd_din = rnd[15:8];
    snd_wr  = 1'b1;
    @(negedge clk);
    snd_wr = 1'b0;
    check_val("mcu_intn[1] low", 32'(0), 32'(mcu_intn[1]));
    mcu_read(5'd3, val);
    check_val("sound latch", 32'(rnd[15:8]), 32'(val));
    check_val("mcu_intn[1] released", 32'(1), 32'(mcu_intn[1]));
    end_test();
endtask

task automatic vblank_irq();
    int n;

    start_test("cpu_irq");
    @(negedge clk);
    vint = 1'b1;
    @(negedge clk);
    vint = 1'b0;
    check_val("cpu_ipl_n", 32'(3), 32'(cpu_ipl_n));
    check_val("mcu_intn[0]", 32'(0), 32'(mcu_intn[0]));
    n = 0;
    while (!mcu_intn[0] && n < 100) begin
        @(negedge clk);
        n++;
    end
    check_val("vblank pulse length", 32'(`BM_VINT_LEN), 32'(n));
    check_val("ipl held", 32'(3), 32'(cpu_ipl_n));
    ack_cycle();
    check_val("ipl after ack", 32'(7), 32'(cpu_ipl_n));
    end_test();
endtask

task automatic halt_and_reset();
    start_test("cpu_control");
    cpu_reg_write(5'd2, 8'h02);
    check_val("cpu_halt_n", 32'(0), 32'(cpu_halt_n));
    cpu_reg_write(5'd2, 8'h01);
    @(negedge clk);
    check_val("cpu_rst set", 32'(1), 32'(cpu_rst));
    check_val("cpu_halt_n off", 32'(1), 32'(cpu_halt_n));
    cpu_reg_write(5'd2, 8'h00);
    @(negedge clk);
    check_val("cpu_rst clear", 32'(0), 32'(cpu_rst));
    end_test();
endtask

task automatic mcu_ipl_override();
    logic [31:0] rnd;
    logic [2:0]  lvl;

    start_test("mcu_irq");
    rnd = $urandom();
    lvl = rnd[2:0] % 3'd7;   // any level except 7
    mcu_write(5'd4, {5'h00, lvl});   // first MCU write takes control
    check_val("cpu_ipl_n", 32'(lvl), 32'(cpu_ipl_n));
    ack_cycle();
    check_val("ipl after ack", 32'(7), 32'(cpu_ipl_n));
    end_test();
endtask

task automatic wait_master();
    int n;

    n = 0;
    while (br_n && n < 20) begin
        @(negedge clk);
        n++;
    end
    if (br_n) report("br_n never went low after the command");
    mcu.acc  = 1'b1;
    mcu.wr   = 1'b0;
    mcu.addr = 5'd2;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (mcu_din[6] && n < 200);
    if (mcu_din[6]) report("bus master stayed busy");
    mcu.acc = 1'b0;
endtask

task automatic master_access();
    logic [31:0] rnd;
    logic [22:0] waddr;
    logic [22:0] raddr;
    logic [15:0] wdata;
    logic [7:0]  hi;
    logic [7:0]  lo;
    int          count0;

    start_test("bus_master");
    rnd   = $urandom();
    waddr = rnd[22:0];
    rnd   = $urandom();
    wdata = rnd[15:0];
    mcu_write(5'd0, wdata[15:8]);
    mcu_write(5'd1, wdata[7:0]);
    mcu_write(5'd10, {1'b0, waddr[22:16]});
    mcu_write(5'd11, waddr[15:8]);
    mcu_write(5'd12, waddr[7:0]);
    count0 = wr_count;
    mcu_write(5'd5, 8'h01);
    wait_master();
    if (wr_count == count0) report("memory saw no write cycle");
    check_val("write addr", 32'(waddr), 32'(last_addr));
    check_val("write data", 32'(wdata), 32'(last_data));
    check_val("write rnw", 32'(0), 32'(last_rnw));
    raddr = waddr ^ 23'h1;   // neighbour word still holds its fill value
    mcu_write(5'd7, {1'b0, raddr[22:16]});
    mcu_write(5'd8, raddr[15:8]);
    mcu_write(5'd9, raddr[7:0]);
    mcu_write(5'd5, 8'h02);
    wait_master();
    mcu_read(5'd0, hi);
    mcu_read(5'd1, lo);
    check_val("read data", 32'(fill_word(raddr[7:0])), 32'({hi, lo}));
    end_test();
endtask

`endif

// File: tb/bus_mapper_tb.sv
/*
 * Testbench for the bus mapper. Plays the CPU, the MCU and the sound CPU,
 * models the bus grant logic and a 256 word memory with random wait,
 * and runs the test sequence from the included task file.
 */
`timescale 1ns/1ps
`include "bus_mapper_params.svh"

module bus_mapper_tb;
    import bus_mapper_pkg::*;

    localparam int MAX_CYCLES = 4000;   // whole sequence needs well under 1000

    logic                   clk;
    logic                   rst;
    cpu_bus_t               cpu;
    logic                   ext_ack_n;
    logic                   bg_n = 1'b1;
    logic                   vint;
    mcu_req_t               mcu;
    logic                   snd_wr;
    logic                   snd_rd;
    logic [7:0]             snd_din;
    logic                   mem_busy = 1'b0;
    logic [15:0]            bus_dout;
    logic                   dtack_n;
    logic                   br_n;
    logic                   bgack_n;
    logic [2:0]             cpu_ipl_n;
    logic                   cpu_vpa_n;
    logic                   cpu_rst;
    logic                   cpu_halt_n;
    logic [`BM_REGIONS-1:0] active;
    logic [23:1]            addr_out;
    logic [15:0]            bus_din;
    logic                   bus_rnw;
    logic                   bus_as_n;
    logic [7:0]             snd_dout;
    logic                   snd_pbf;
    logic [7:0]             mcu_din;
    logic [1:0]             mcu_intn;

    logic [15:0] mem [0:255];
    int          wr_count = 0;        // owned write cycles seen by the memory
    logic [23:1] last_addr = '0;
    logic [15:0] last_data = '0;
    logic        last_rnw = 1'b1;

    int    cycles = 0;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    test_err0 = 0;
    string cur_test = "reset";

    bus_mapper_top bus_mapper_top_inst (
        .clk(clk), .rst(rst), .cpu(cpu), .ext_ack_n(ext_ack_n), .bg_n(bg_n),
        .vint(vint), .mcu(mcu), .snd_wr(snd_wr), .snd_rd(snd_rd), .snd_din(snd_din),
        .mem_busy(mem_busy), .bus_dout(bus_dout), .dtack_n(dtack_n), .br_n(br_n),
        .bgack_n(bgack_n), .cpu_ipl_n(cpu_ipl_n), .cpu_vpa_n(cpu_vpa_n),
        .cpu_rst(cpu_rst), .cpu_halt_n(cpu_halt_n), .active(active),
        .addr_out(addr_out), .bus_din(bus_din), .bus_rnw(bus_rnw), .bus_as_n(bus_as_n),
        .snd_dout(snd_dout), .snd_pbf(snd_pbf), .mcu_din(mcu_din), .mcu_intn(mcu_intn)
    );

    `include "bus_mapper_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // grant only while the CPU is between cycles
    always @(negedge clk) begin
        bg_n     <= ~(~br_n & cpu.as_n);
        mem_busy <= ~bgack_n & (($urandom() % 3) == 0);
    end

    assign bus_dout = mem[addr_out[8:1]];

    always @(posedge clk) begin
        if (!bgack_n && !bus_as_n && !mem_busy) begin
            last_addr <= addr_out;
            last_data <= bus_din;
            last_rnw  <= bus_rnw;
            if (!bus_rnw) begin
                mem[addr_out[8:1]] <= bus_din;
                wr_count           <= wr_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'he510_1fa2));
        for (int i = 0; i < 256; i++) begin
            mem[i] <= fill_word(8'(i));
        end
        rst       = 1'b1;
        cpu       = '0;
        cpu.as_n  = 1'b1;
        cpu.rnw   = 1'b1;
        cpu.dsn   = 2'b11;
        cpu.fc    = 3'b101;
        ext_ack_n = 1'b1;
        vint      = 1'b0;
        mcu       = '0;
        snd_wr    = 1'b0;
        snd_rd    = 1'b0;
        snd_din   = 8'h00;
        repeat (5) @(posedge clk);
        reset_values();
        region_sweep();
        dtack_delays();
        sound_mailbox();
        vblank_irq();
        halt_and_reset();
        mcu_ipl_override();
        master_access();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: bus_mapper.f
+incdir+hw
+incdir+tb
hw/bus_mapper_pkg.sv
hw/mapper_regs.sv
hw/region_decode.sv
hw/dtack_timer.sv
hw/mcu_bus_master.sv
hw/irq_ctrl.sv
hw/bus_mapper_top.sv
tb/bus_mapper_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus mapper testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f bus_mapper.f \
    --top-module bus_mapper_tb -o bus_mapper_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/bus_mapper_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
